// File: wb_commit.f
src/wb_commit_pkg.sv
src/wb_arbiter.sv
src/reorder_buffer.sv
src/writeback_commit_unit.sv
sim/wb_commit_checker.sv
sim/wb_commit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the writeback-commit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module wb_commit_tb -f wb_commit.f -o wb_commit_sim

status=0
out=$(./obj_dir/wb_commit_sim 2>&1) || status=$?
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Test OK"
exit "$status"

// File: sim/wb_commit_tb.sv
// Writeback-commit testbench
// Directed tests with a commit scoreboard, inputs driven on the falling edge

`default_nettype none

module wb_commit_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 10;
  // Far above the few hundred cycles the tests need
  localparam int MAX_CYCLES  = 2000;

  logic                                                 clk = 1'b0;
  logic                                                 rst;
  wb_commit_pkg::x_w_msg_t [wb_commit_pkg::NUM_PIPES-1:0] x_msg;
  logic                    [wb_commit_pkg::NUM_PIPES-1:0] x_val;
  logic                    [wb_commit_pkg::NUM_PIPES-1:0] x_rdy;
  wb_commit_pkg::complete_msg_t                         complete_msg;
  logic                                                 complete_val;
  wb_commit_pkg::commit_msg_t                           commit_msg;
  logic                                                 commit_val;

  // Scoreboard state owned by the monitor
  wb_commit_pkg::x_w_msg_t             exp_entry [wb_commit_pkg::ROB_DEPTH];
  logic [wb_commit_pkg::ROB_DEPTH-1:0] exp_valid = '0;
  logic [wb_commit_pkg::SEQ_BITS-1:0]  exp_head = '0;
  int outstanding = 0;
  int commit_cyc [wb_commit_pkg::ROB_DEPTH];
  int commit_log [$];
  // Driver side
  wb_commit_pkg::x_w_msg_t pend [wb_commit_pkg::NUM_PIPES][$];
  int          comp_cyc [wb_commit_pkg::ROB_DEPTH];
  int          grant_log [$];
  int          cycle = 0;
  logic [31:0] rng_state = 32'he24e2d62;
  logic [31:0] pc_next = 32'h0000_1000;
  string       cur_test = "reset";

  writeback_commit_unit dut_i (
    .clk          (clk),
    .rst          (rst),
    .x_msg        (x_msg),
    .x_val        (x_val),
    .x_rdy        (x_rdy),
    .complete_msg (complete_msg),
    .complete_val (complete_val),
    .commit_msg   (commit_msg),
    .commit_val   (commit_val)
  );

  always #HALF_PERIOD clk = ~clk;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  task automatic halt_run();
    $display("Test FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(string what, logic [79:0] expected, logic [79:0] actual);
    if (expected !== actual) begin
      $display("Mismatch in %s, %s: expected %h, actual %h", cur_test, what, expected, actual);
      halt_run();
    end
  endtask

  // LCG step
  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Random payload with the pc counting up by one instruction
  task automatic queue_msg(input int pipe, input int seq);
    wb_commit_pkg::x_w_msg_t m;
    logic [31:0]             r;
    r         = next_random();
    m.pc      = pc_next;
    m.seq_num = wb_commit_pkg::SEQ_BITS'(seq);
    m.waddr   = r[wb_commit_pkg::REG_BITS-1:0];
    m.wen     = r[8];
    m.wdata   = next_random();
    pc_next   = pc_next + 32'd4;
    pend[pipe].push_back(m);
  endtask

  // Offer all queued messages and check each completion one cycle later
  task automatic drive_all(input bit gaps);
    wb_commit_pkg::x_w_msg_t      acc;
    wb_commit_pkg::complete_msg_t exp_m;
    logic [31:0]                  r;
    bit                           have_acc;
    bit                           busy;
    int                           drop;
    int                           grant;
    int                           left;
    have_acc = 1'b0;
    busy     = 1'b1;
    drop     = -1;
    while (busy) begin
      if (drop >= 0) begin
        x_val[drop] = 1'b0;
      end
      if (have_acc) begin
        exp_m.seq_num = acc.seq_num;
        exp_m.waddr   = acc.waddr;
        exp_m.wdata   = acc.wdata;
        exp_m.wen     = acc.wen;
        check("complete_val", 80'(1'b1), 80'(complete_val));
        check("completion", 80'(exp_m), 80'(complete_msg));
        comp_cyc[acc.seq_num] = cycle;
      end else begin
        check("idle complete_val", 80'(1'b0), 80'(complete_val));
      end
      have_acc = 1'b0;
      drop     = -1;
      left     = 0;
      // Idle pipes pick up their next message, sometimes pausing
      for (int p = 0; p < wb_commit_pkg::NUM_PIPES; p++) begin
        r = next_random();
        if (!x_val[p] && pend[p].size() > 0 && !(gaps && r[3])) begin
          x_msg[p] = pend[p].pop_front();
          x_val[p] = 1'b1;
        end
        left = left + pend[p].size();
      end
      if (x_val == '0 && left == 0) begin
        busy = 1'b0;
      end else begin
        #1;
        grant = -1;
        for (int p = 0; p < wb_commit_pkg::NUM_PIPES; p++) begin
          if (x_val[p] && x_rdy[p]) begin
            grant = p;
          end
        end
        if (x_val != '0 && grant < 0) begin
          $display("No pipe was granted although a pipe was valid");
          halt_run();
        end else if (grant >= 0) begin
          acc      = x_msg[grant];
          have_acc = 1'b1;
          drop     = grant;
          grant_log.push_back(grant);
        end
        @(negedge clk);
      end
    end
  endtask

  task automatic wait_drain();
    while (outstanding > 0) begin
      @(negedge clk);
    end
  endtask

  // ----------------------------------------
  // Monitor and timeout
  // ----------------------------------------

  // Commits against the model head, then log the transfer of this cycle
  always @(negedge clk) begin
    wb_commit_pkg::commit_msg_t exp_c;
    wb_commit_pkg::x_w_msg_t    acc;
    if (commit_val) begin
      if (!exp_valid[exp_head]) begin
        $display("Commit seen while sequence %0d at the head was never sent", exp_head);
        halt_run();
      end else begin
        exp_c.pc      = exp_entry[exp_head].pc;
        exp_c.seq_num = exp_head;
        exp_c.waddr   = exp_entry[exp_head].waddr;
        exp_c.wdata   = exp_entry[exp_head].wdata;
        exp_c.wen     = exp_entry[exp_head].wen;
        check("commit", 80'(exp_c), 80'(commit_msg));
        commit_cyc[exp_head] = cycle;
        commit_log.push_back(int'(commit_msg.seq_num));
        exp_valid[exp_head]  = 1'b0;
        exp_head             = exp_head + 1'b1;
        outstanding--;
      end
    end
    #1;
    for (int p = 0; p < wb_commit_pkg::NUM_PIPES; p++) begin
      if (x_val[p] && x_rdy[p]) begin
        acc = x_msg[p];
        exp_entry[acc.seq_num] = acc;
        exp_valid[acc.seq_num] = 1'b1;
        outstanding++;
      end
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle);
      halt_run();
    end
  end

  // ----------------------------------------
  // Tests
  // ----------------------------------------

  task automatic test_reset();
    cur_test = "reset";
    for (int k = 0; k <= 4; k++) begin
      @(negedge clk);
      // Four reset cycles, then the first cycle out of reset
      if (k == 3) begin
        rst = 1'b0;
      end
      check("x_rdy", 80'(0), 80'(x_rdy));
      check("complete_val", 80'(0), 80'(complete_val));
      check("commit_val", 80'(0), 80'(commit_val));
    end
  endtask

  task automatic test_in_order();
    int base;
    cur_test = "in_order";
    base     = int'(exp_head);
    for (int k = 0; k < 4; k++) begin
      queue_msg(0, base + k);
    end
    drive_all(1'b0);
    wait_drain();
    for (int k = 0; k < 4; k++) begin
      check("commit latency", 80'(comp_cyc[(base + k) % wb_commit_pkg::ROB_DEPTH] + 1),
            80'(commit_cyc[(base + k) % wb_commit_pkg::ROB_DEPTH]));
    end
  endtask

  task automatic test_out_of_order();
    int base;
    int mark;
    cur_test = "out_of_order";
    base     = int'(exp_head);
    mark     = commit_log.size();
    queue_msg(0, base + 3);
    queue_msg(0, base + 1);
    queue_msg(0, base + 2);
    drive_all(1'b0);
    @(negedge clk);
    // Head result still missing
    check("early commits", 80'(mark), 80'(commit_log.size()));
    queue_msg(0, base);
    drive_all(1'b0);
    wait_drain();
    for (int k = 0; k < 4; k++) begin
      check("commit cycle", 80'(comp_cyc[base % wb_commit_pkg::ROB_DEPTH] + 1 + k),
            80'(commit_cyc[(base + k) % wb_commit_pkg::ROB_DEPTH]));
    end
  endtask

  task automatic test_two_pipe();
    int base;
    int mark;
    cur_test = "two_pipe";
    base     = int'(exp_head);
    mark     = grant_log.size();
    for (int k = 0; k < 8; k++) begin
      queue_msg(k % 2, base + k);
    end
    drive_all(1'b0);
    wait_drain();
    check("grant count", 80'(8), 80'(grant_log.size() - mark));
    for (int k = mark + 1; k < grant_log.size(); k++) begin
      check("grant alternation", 80'(1 - grant_log[k - 1]), 80'(grant_log[k]));
    end
  endtask

  task automatic test_random_wrap();
    int order [wb_commit_pkg::ROB_DEPTH];
    int base;
    int mark;
    int j;
    int t;
    cur_test = "random_wrap";
    for (int r = 0; r < 3; r++) begin
      base = int'(exp_head);
      mark = commit_log.size();
      for (int k = 0; k < wb_commit_pkg::ROB_DEPTH; k++) begin
        order[k] = k;
      end
      // Fisher-Yates shuffle
      for (int k = wb_commit_pkg::ROB_DEPTH - 1; k > 0; k--) begin
        j        = int'(next_random() % 32'(k + 1));
        t        = order[k];
        order[k] = order[j];
        order[j] = t;
      end
      for (int k = 0; k < wb_commit_pkg::ROB_DEPTH; k++) begin
        queue_msg(int'(next_random() % 32'(wb_commit_pkg::NUM_PIPES)), base + order[k]);
      end
      drive_all(1'b1);
      wait_drain();
      for (int k = 0; k < wb_commit_pkg::ROB_DEPTH; k++) begin
        check("commit order", 80'((base + k) % wb_commit_pkg::ROB_DEPTH),
              80'(commit_log[mark + k]));
      end
    end
  endtask

  initial begin
    rst   = 1'b1;
    x_val = '0;
    x_msg = '0;
    test_reset();
    test_in_order();
    test_out_of_order();
    test_two_pipe();
    test_random_wrap();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/wb_commit_checker.sv
// Writeback-commit assertions
// Handshake, completion timing, sequence reuse and reset rules

`default_nettype none

module wb_commit_checker (
  input logic                                                 clk,
  input logic                                                 rst,
  input wb_commit_pkg::x_w_msg_t [wb_commit_pkg::NUM_PIPES-1:0] x_msg,
  input logic                    [wb_commit_pkg::NUM_PIPES-1:0] x_val,
  input logic                    [wb_commit_pkg::NUM_PIPES-1:0] x_rdy,
  input wb_commit_pkg::complete_msg_t                         complete_msg,
  input logic                                                 complete_val,
  input wb_commit_pkg::commit_msg_t                           commit_msg,
  input logic                                                 commit_val
);
  timeunit 1ns;
  timeprecision 1ps;

  // Sequence numbers completed but not yet committed
  logic [wb_commit_pkg::ROB_DEPTH-1:0] in_flight;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
    end else begin
      if (commit_val) begin
        in_flight[commit_msg.seq_num] <= 1'b0;
      end
      if (complete_val) begin
        in_flight[complete_msg.seq_num] <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Handshake
  // ----------------------------------------

  assert property (@(posedge clk) $onehot0(x_rdy))
    else $error("more than one x_rdy bit is high");

  // Offered message stays put until granted
  for (genvar p = 0; p < wb_commit_pkg::NUM_PIPES; p++) begin : g_hold
    assert property (@(posedge clk) disable iff (rst)
      x_val[p] && !x_rdy[p] |=> x_val[p] && $stable(x_msg[p]))
      else $error("pipe %0d dropped or changed a pending message", p);
  end

  // ----------------------------------------
  // Completion and reset
  // ----------------------------------------

  assert property (@(posedge clk) disable iff (rst) (|(x_val & x_rdy)) |=> complete_val)
    else $error("transfer not followed by a completion");

  assert property (@(posedge clk) disable iff (rst) !(|(x_val & x_rdy)) |=> !complete_val)
    else $error("completion without a transfer");

  // Issuer must not reuse an outstanding seq num
  assert property (@(posedge clk) disable iff (rst)
    complete_val |-> !in_flight[complete_msg.seq_num])
    else $error("completion hit an entry that is still outstanding");

  assert property (@(posedge clk) rst |=> !complete_val && !commit_val)
    else $error("valid output in the cycle after reset");

endmodule

bind writeback_commit_unit wb_commit_checker checker_i (
  .clk          (clk),
  .rst          (rst),
  .x_msg        (x_msg),
  .x_val        (x_val),
  .x_rdy        (x_rdy),
  .complete_msg (complete_msg),
  .complete_val (complete_val),
  .commit_msg   (commit_msg),
  .commit_val   (commit_val)
);

`default_nettype wire

// File: src/writeback_commit_unit.sv
// Writeback-commit unit
// Arbiter picks one execute result per cycle and announces it as a
// completion, the reorder buffer commits results in sequence order

`default_nettype none

module writeback_commit_unit (
  input  logic                                                 clk,
  input  logic                                                 rst,

  // Execute pipes
  input  wb_commit_pkg::x_w_msg_t [wb_commit_pkg::NUM_PIPES-1:0] x_msg,
  input  logic                    [wb_commit_pkg::NUM_PIPES-1:0] x_val,
  output logic                    [wb_commit_pkg::NUM_PIPES-1:0] x_rdy,

  // Completion notification, wakes dependents
  output wb_commit_pkg::complete_msg_t                         complete_msg,
  output logic                                                 complete_val,

  // Commit notification, to the register file
  output wb_commit_pkg::commit_msg_t                           commit_msg,
  output logic                                                 commit_val
);

  // ----------------------------------------
  // Arbiter to ROB
  // ----------------------------------------

  // Completion carries no pc, it rides alongside
  logic [31:0] complete_pc;

  wb_arbiter arbiter_i (
    .clk          (clk),
    .rst          (rst),
    .x_msg        (x_msg),
    .x_val        (x_val),
    .x_rdy        (x_rdy),
    .complete_msg (complete_msg),
    .complete_pc  (complete_pc),
    .complete_val (complete_val)
  );

  // Same completion pair feeds the ROB write port
  reorder_buffer rob_i (
    .clk          (clk),
    .rst          (rst),
    .complete_msg (complete_msg),
    .complete_pc  (complete_pc),
    .complete_val (complete_val),
    .commit_msg   (commit_msg),
    .commit_val   (commit_val)
  );

endmodule

`default_nettype wire

// File: src/reorder_buffer.sv
// Reorder buffer
// Stores completed results by sequence number and commits them
// strictly in order from a head pointer, one per cycle at most

`default_nettype none

module reorder_buffer (
  input  logic                         clk,
  input  logic                         rst,
  input  wb_commit_pkg::complete_msg_t complete_msg,
  input  logic [31:0]                  complete_pc,
  input  logic                         complete_val,
  output wb_commit_pkg::commit_msg_t   commit_msg,
  output logic                         commit_val
);

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  // Result slots, indexed by seq num
  wb_commit_pkg::commit_msg_t             entry_mem [wb_commit_pkg::ROB_DEPTH];
  logic [wb_commit_pkg::ROB_DEPTH-1:0]    entry_valid;
  // Oldest outstanding sequence number
  logic [wb_commit_pkg::SEQ_BITS-1:0]     head;

  // Incoming completion rebuilt as a commit-shaped entry
  wb_commit_pkg::commit_msg_t             incoming;
  // Completion is the head and the slot is empty, commit it directly
  logic                                   bypass;
  // Completion goes into storage
  logic                                   write_en;
  logic                                   head_valid;
  logic                                   commit_go;
  wb_commit_pkg::commit_msg_t             commit_next;

  always_comb begin
    incoming.pc      = complete_pc;
    incoming.seq_num = complete_msg.seq_num;
    incoming.waddr   = complete_msg.waddr;
    incoming.wdata   = complete_msg.wdata;
    incoming.wen     = complete_msg.wen;
  end

  // ----------------------------------------
  // Commit select
  // ----------------------------------------

  assign head_valid = entry_valid[head];
  assign bypass     = complete_val && !head_valid && (complete_msg.seq_num == head);
  assign write_en   = complete_val && !bypass;
  assign commit_go  = head_valid || bypass;

  // Stored head first, otherwise the arriving result
  always_comb begin
    if (head_valid) begin
      commit_next = entry_mem[head];
    end else begin
      commit_next = incoming;
    end
  end

  // ----------------------------------------
  // Valid bits and head
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      entry_valid <= '0;
      head        <= '0;
      commit_val  <= 1'b0;
    end else begin
      commit_val <= commit_go;
      // Retire the head; bypassed results never set their bit
      if (head_valid) begin
        entry_valid[head] <= 1'b0;
      end
      if (commit_go) begin
        // Wraps with the seq num since depth is a power of two
        head <= head + 1'b1;
      end
      // Slot differs from the head here, so no clash with the clear
      if (write_en) begin
        entry_valid[complete_msg.seq_num] <= 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Payload
  // ----------------------------------------

  // Slot contents
  always_ff @(posedge clk) begin
    if (write_en) begin
      entry_mem[complete_msg.seq_num] <= incoming;
    end
  end

  // Commit register, held between commits
  always_ff @(posedge clk) begin
    if (commit_go) begin
      commit_msg <= commit_next;
    end
  end

endmodule

`default_nettype wire

// File: src/wb_arbiter.sv
// Writeback arbiter
// Round-robin pick of one execute pipe per cycle, then a registered
// completion stage that carries the accepted result and its pc

`default_nettype none

module wb_arbiter (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  wb_commit_pkg::x_w_msg_t [wb_commit_pkg::NUM_PIPES-1:0] x_msg,
  input  logic                    [wb_commit_pkg::NUM_PIPES-1:0] x_val,
  output logic                    [wb_commit_pkg::NUM_PIPES-1:0] x_rdy,
  output wb_commit_pkg::complete_msg_t                         complete_msg,
  output logic                    [31:0]                       complete_pc,
  output logic                                                 complete_val
);

  // ----------------------------------------
  // Round-robin grant
  // ----------------------------------------

  // Pipe with top priority this cycle
  logic [$clog2(wb_commit_pkg::NUM_PIPES)-1:0] rr_ptr;
  logic [$clog2(wb_commit_pkg::NUM_PIPES)-1:0] grant_idx;
  logic [$clog2(wb_commit_pkg::NUM_PIPES)-1:0] next_ptr;
  logic                                        any_val;
  wb_commit_pkg::x_w_msg_t                     sel_msg;

  assign any_val = |x_val;

  // Scan from the pointer, first valid pipe wins
  always_comb begin
    int idx;
    logic found;
    idx       = 0;
    found     = 1'b0;
    grant_idx = rr_ptr;
    x_rdy     = '0;
    for (int k = 0; k < wb_commit_pkg::NUM_PIPES; k++) begin
      idx = (int'(rr_ptr) + k) % wb_commit_pkg::NUM_PIPES;
      if (!found && x_val[idx]) begin
        found      = 1'b1;
        grant_idx  = idx[$clog2(wb_commit_pkg::NUM_PIPES)-1:0];
        x_rdy[idx] = 1'b1;
      end
    end
  end

  // Pointer lands just past the granted pipe
  always_comb begin
    int nxt;
    nxt      = (int'(grant_idx) + 1) % wb_commit_pkg::NUM_PIPES;
    next_ptr = nxt[$clog2(wb_commit_pkg::NUM_PIPES)-1:0];
  end

  assign sel_msg = x_msg[grant_idx];

  // ----------------------------------------
  // Completion stage
  // ----------------------------------------

  // Control: one-cycle valid per accept, pointer moves on transfer only
  always_ff @(posedge clk) begin
    if (rst) begin
      complete_val <= 1'b0;
      rr_ptr       <= '0;
    end else begin
      complete_val <= any_val;
      if (any_val) begin
        rr_ptr <= next_ptr;
      end
    end
  end

  // Payload, split into completion fields plus pc
  always_ff @(posedge clk) begin
    if (any_val) begin
      complete_msg.seq_num <= sel_msg.seq_num;
      complete_msg.waddr   <= sel_msg.waddr;
      complete_msg.wdata   <= sel_msg.wdata;
      complete_msg.wen     <= sel_msg.wen;
      complete_pc          <= sel_msg.pc;
    end
  end

endmodule

`default_nettype wire

// File: src/wb_commit_pkg.sv
// Writeback/commit package
// Widths, pipe count, reorder depth and the message structs shared
// by the writeback arbiter, the reorder buffer and the top level

`default_nettype none

package wb_commit_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------

  // Execute pipes feeding writeback
  localparam int NUM_PIPES = 2;
  // Sequence number width
  localparam int SEQ_BITS  = 3;
  // One entry per sequence number, so the seq num is the index
  localparam int ROB_DEPTH = 2 ** SEQ_BITS;
  localparam int DATA_BITS = 32;
  // Architectural register address
  localparam int REG_BITS  = 5;

  // ----------------------------------------
  // Messages
  // ----------------------------------------

  // Execute to writeback
  typedef struct packed {
    logic [31:0]          pc;
    logic [SEQ_BITS-1:0]  seq_num;
    logic [REG_BITS-1:0]  waddr;
    logic [DATA_BITS-1:0] wdata;
    logic                 wen;
  } x_w_msg_t;

  // Completion, wakes up dependents (no pc)
  typedef struct packed {
    logic [SEQ_BITS-1:0]  seq_num;
    logic [REG_BITS-1:0]  waddr;
    logic [DATA_BITS-1:0] wdata;
    logic                 wen;
  } complete_msg_t;

  // Commit, goes to the architectural register file
  typedef struct packed {
    logic [31:0]          pc;
    logic [SEQ_BITS-1:0]  seq_num;
    logic [REG_BITS-1:0]  waddr;
    logic [DATA_BITS-1:0] wdata;
    logic                 wen;
  } commit_msg_t;

endpackage

`default_nettype wire
